// File: source/dccm_ctl_config.svh
`ifndef DCCM_CTL_CONFIG_SVH
`define DCCM_CTL_CONFIG_SVH

// dccm byte address width
`define DCCM_ADDR_BITS 16

// one bank word and its check bits
`define DCCM_DATA_BITS 32
`define DCCM_ECC_BITS 7

// address bit that picks the lo or hi bank
`define DCCM_BANK_LSB 2

// dma buffer entry number
`define DMA_TAG_BITS 3

`endif

// File: source/dccm_ctl_pkg.sv
`default_nettype none

`include "dccm_ctl_config.svh"

package dccm_ctl_pkg;

   typedef logic [`DCCM_ADDR_BITS-1:0]                  dccm_addr_t;
   typedef logic [`DCCM_DATA_BITS-1:0]                  dccm_data_t;
   typedef logic [`DCCM_ECC_BITS-1:0]                   dccm_ecc_t;
   typedef logic [`DCCM_DATA_BITS/8-1:0]                dccm_byteen_t;
   typedef logic [`DMA_TAG_BITS-1:0]                    dma_tag_t;
   typedef logic [`DCCM_ECC_BITS+`DCCM_DATA_BITS-1:0]   dccm_fdata_t;  // {ecc, data}

   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic dma;     // access issued on behalf of the dma
      logic by;
      logic half;
      logic word;
      logic dword;
   } lsu_pkt_t;

   // write side of the single dccm port
   typedef struct packed {
      logic        wren;
      dccm_addr_t  addr_lo;
      dccm_addr_t  addr_hi;
      dccm_fdata_t data_lo;
      dccm_fdata_t data_hi;
   } dccm_wr_t;

   typedef struct packed {
      logic        valid;
      logic        use_hi;    // only the hi bank failed
      dccm_addr_t  addr_lo;
      dccm_addr_t  addr_hi;
      dccm_fdata_t fdata_lo;
      dccm_fdata_t fdata_hi;
   } scrub_req_t;

   typedef struct packed {
      logic       reqvld;     // held until commit
      dccm_addr_t addr;
      dccm_data_t data;
      dccm_ecc_t  ecc;
   } stbuf_req_t;

endpackage

`default_nettype wire

// File: source/dccm_port_arb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dccm_ctl_config.svh"

module dccm_port_arb
   import dccm_ctl_pkg::*;
(
   input  wire lsu_pkt_t     lsu_pkt_d,
   input  wire dccm_addr_t   lsu_addr_d,
   input  wire dccm_addr_t   end_addr_d,
   input  wire               addr_in_dccm_d,
   input  wire stbuf_req_t   stbuf,
   input  wire               dma_dccm_wen,
   input  wire dccm_fdata_t  dma_wdata_lo,
   input  wire dccm_fdata_t  dma_wdata_hi,
   input  wire scrub_req_t   scrub,
   output logic              dccm_rden,
   output dccm_addr_t        dccm_rd_addr_lo,
   output dccm_addr_t        dccm_rd_addr_hi,
   output logic              stbuf_commit,
   output dccm_wr_t          dccm_wr
);

   logic rden_d;
   logic stbuf_bank;
   logic bank_clash;

   // aligned word stores overwrite the whole word with fresh ecc, no read needed
   assign rden_d = lsu_pkt_d.valid & addr_in_dccm_d &
                   (lsu_pkt_d.load |
                    (lsu_pkt_d.store & (~(lsu_pkt_d.word | lsu_pkt_d.dword) |
                                        (lsu_addr_d[1:0] != 2'b00))));

   assign dccm_rden       = rden_d;
   assign dccm_rd_addr_lo = lsu_addr_d;
   assign dccm_rd_addr_hi = end_addr_d;   // hi bank reads at the last byte

   assign stbuf_bank = stbuf.addr[`DCCM_BANK_LSB];
   assign bank_clash = (stbuf_bank == lsu_addr_d[`DCCM_BANK_LSB]) |
                       (stbuf_bank == end_addr_d[`DCCM_BANK_LSB]);

   // a read on the other bank can share the cycle with a commit
   assign stbuf_commit = stbuf.reqvld & ~dma_dccm_wen & ~scrub.valid &
                         (~rden_d | ~bank_clash);

   always_comb begin
      dccm_wr.wren = scrub.valid | dma_dccm_wen | stbuf_commit;
      if (scrub.valid) begin                   // failing bank goes out on lo
         dccm_wr.addr_lo = scrub.use_hi ? scrub.addr_hi  : scrub.addr_lo;
         dccm_wr.addr_hi = scrub.use_hi ? scrub.addr_lo  : scrub.addr_hi;
         dccm_wr.data_lo = scrub.use_hi ? scrub.fdata_hi : scrub.fdata_lo;
         dccm_wr.data_hi = scrub.use_hi ? scrub.fdata_lo : scrub.fdata_hi;
      end else if (dma_dccm_wen) begin
         dccm_wr.addr_lo = lsu_addr_d;
         dccm_wr.addr_hi = end_addr_d;
         dccm_wr.data_lo = dma_wdata_lo;
         dccm_wr.data_hi = dma_wdata_hi;
      end else begin
         dccm_wr.addr_lo = stbuf.addr;
         dccm_wr.addr_hi = stbuf.addr;
         dccm_wr.data_lo = {stbuf.ecc, stbuf.data};
         dccm_wr.data_hi = {stbuf.ecc, stbuf.data};
      end
   end

endmodule

`default_nettype wire

// File: source/dccm_ld_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "dccm_ctl_config.svh"

module dccm_ld_pipe
   import dccm_ctl_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire lsu_pkt_t      lsu_pkt_d,
   input  wire dccm_addr_t    lsu_addr_d,
   input  wire dccm_addr_t    end_addr_d,
   input  wire                addr_in_dccm_d,
   input  wire                dccm_rden,
   input  wire dma_tag_t      dma_mem_tag_m,
   input  wire dccm_data_t    stbuf_fwddata_lo_m,
   input  wire dccm_data_t    stbuf_fwddata_hi_m,
   input  wire dccm_byteen_t  stbuf_fwdbyteen_lo_m,
   input  wire dccm_byteen_t  stbuf_fwdbyteen_hi_m,
   input  wire dccm_fdata_t   dccm_rd_data_lo,
   input  wire dccm_fdata_t   dccm_rd_data_hi,
   input  wire dccm_data_t    sec_data_lo_r,
   input  wire dccm_data_t    sec_data_hi_r,
   input  wire                double_ecc_error_r,
   output lsu_pkt_t           lsu_pkt_r,
   output dccm_addr_t         lsu_addr_r,
   output dccm_addr_t         end_addr_r,
   output dccm_data_t         lsu_ld_data_r,        // right justified
   output dccm_data_t         lsu_ld_data_corr_r,
   output logic               dccm_dma_rvalid,
   output logic               dccm_dma_ecc_error,
   output dma_tag_t           dccm_dma_rtag,
   output dccm_data_t [1:0]   dccm_dma_rdata
);

   localparam int WORD_BITS = `DCCM_DATA_BITS;
   localparam int PAIR_BYTES = 2 * WORD_BITS / 8;

   lsu_pkt_t                 lsu_pkt_m;
   dccm_addr_t               lsu_addr_m;
   dccm_addr_t               end_addr_m;
   logic                     in_dccm_m;
   logic                     in_dccm_r;
   logic                     rden_m;
   dccm_data_t               rdata_lo_r;
   dccm_data_t               rdata_hi_r;
   dccm_data_t               fwddata_lo_r;
   dccm_data_t               fwddata_hi_r;
   dccm_byteen_t             fwdbyteen_lo_r;
   dccm_byteen_t             fwdbyteen_hi_r;
   dma_tag_t                 dma_tag_r;
   logic [2*WORD_BITS-1:0]   rdata_pair_r;
   logic [2*WORD_BITS-1:0]   fwd_pair_r;
   logic [2*WORD_BITS-1:0]   sec_pair_r;
   logic [2*WORD_BITS-1:0]   ld_raw_r;
   logic [2*WORD_BITS-1:0]   ld_corr_r;
   logic [2*WORD_BITS-1:0]   ld_raw_sh;
   logic [2*WORD_BITS-1:0]   ld_corr_sh;
   logic [PAIR_BYTES-1:0]    fwd_byteen_r;
   logic                     dual_r;

   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_pkt_m <= '0;
         lsu_pkt_r <= '0;
         rden_m    <= 1'b0;
      end else begin
         lsu_pkt_m <= lsu_pkt_d;
         lsu_pkt_r <= lsu_pkt_m;
         rden_m    <= dccm_rden;
      end
   end

   always_ff @(posedge clk) begin
      lsu_addr_m     <= lsu_addr_d;
      end_addr_m     <= end_addr_d;
      in_dccm_m      <= addr_in_dccm_d;
      lsu_addr_r     <= lsu_addr_m;
      end_addr_r     <= end_addr_m;
      in_dccm_r      <= in_dccm_m;
      fwdbyteen_lo_r <= stbuf_fwdbyteen_lo_m;
      fwdbyteen_hi_r <= stbuf_fwdbyteen_hi_m;
      dma_tag_r      <= dma_mem_tag_m;
      if (rden_m) begin                      // memory output only valid after a read
         rdata_lo_r <= dccm_rd_data_lo[WORD_BITS-1:0];
         rdata_hi_r <= dccm_rd_data_hi[WORD_BITS-1:0];
      end
      if (|{stbuf_fwdbyteen_hi_m, stbuf_fwdbyteen_lo_m}) begin
         fwddata_lo_r <= stbuf_fwddata_lo_m;
         fwddata_hi_r <= stbuf_fwddata_hi_m;
      end
   end

   assign fwd_byteen_r = {fwdbyteen_hi_r, fwdbyteen_lo_r};
   assign rdata_pair_r = {rdata_hi_r, rdata_lo_r};
   assign fwd_pair_r   = {fwddata_hi_r, fwddata_lo_r};
   assign sec_pair_r   = {sec_data_hi_r, sec_data_lo_r};

   // forwarded bytes win over the memory
   for (genvar i = 0; i < PAIR_BYTES; i++) begin : g_merge
      assign ld_raw_r[8*i +: 8]  = fwd_byteen_r[i] ? fwd_pair_r[8*i +: 8] :
                                   ({8{in_dccm_r}} & rdata_pair_r[8*i +: 8]);
      assign ld_corr_r[8*i +: 8] = fwd_byteen_r[i] ? fwd_pair_r[8*i +: 8] :
                                   ({8{in_dccm_r}} & sec_pair_r[8*i +: 8]);
   end

   assign ld_raw_sh          = ld_raw_r >> {lsu_addr_r[1:0], 3'b000};
   assign ld_corr_sh         = ld_corr_r >> {lsu_addr_r[1:0], 3'b000};
   assign lsu_ld_data_r      = ld_raw_sh[WORD_BITS-1:0];
   assign lsu_ld_data_corr_r = ld_corr_sh[WORD_BITS-1:0];

   assign dual_r = lsu_addr_r[`DCCM_BANK_LSB] != end_addr_r[`DCCM_BANK_LSB];  // straddles banks

   assign dccm_dma_rvalid    = lsu_pkt_r.valid & lsu_pkt_r.load & lsu_pkt_r.dma;
   assign dccm_dma_ecc_error = double_ecc_error_r;
   assign dccm_dma_rtag      = dma_tag_r;
   assign dccm_dma_rdata     = dual_r ? ld_corr_r : {2{ld_corr_r[WORD_BITS-1:0]}};

endmodule

`default_nettype wire

// File: source/dccm_ecc_scrub.sv
`timescale 1ns/10ps
`default_nettype none

module dccm_ecc_scrub
   import dccm_ctl_pkg::*;
(
   input  wire              clk,
   input  wire              reset,
   input  wire lsu_pkt_t    lsu_pkt_r,
   input  wire dccm_addr_t  lsu_addr_r,
   input  wire dccm_addr_t  end_addr_r,
   input  wire              lsu_commit_r,
   input  wire              single_ecc_error_lo_r,
   input  wire              single_ecc_error_hi_r,
   input  wire              double_ecc_error_r,
   input  wire dccm_data_t  sec_data_lo_r,
   input  wire dccm_data_t  sec_data_hi_r,
   input  wire dccm_ecc_t   sec_ecc_lo_r,
   input  wire dccm_ecc_t   sec_ecc_hi_r,
   output logic             ld_single_ecc_error_r,
   output scrub_req_t       scrub
);

   logic ld_err_lo_r;
   logic ld_err_hi_r;
   logic scrub_ns;

   assign ld_err_lo_r = lsu_pkt_r.valid & lsu_pkt_r.load & single_ecc_error_lo_r;
   assign ld_err_hi_r = lsu_pkt_r.valid & lsu_pkt_r.load & single_ecc_error_hi_r;

   // a double error is not correctable, nothing to write back
   assign ld_single_ecc_error_r = (ld_err_lo_r | ld_err_hi_r) & ~double_ecc_error_r;

   // speculative loads that never commit leave memory alone
   assign scrub_ns = ld_single_ecc_error_r & (lsu_commit_r | lsu_pkt_r.dma);

   always_ff @(posedge clk) begin
      if (reset) begin
         scrub.valid <= 1'b0;
      end else begin
         scrub.valid <= scrub_ns;    // one-shot request
      end
      if (scrub_ns) begin
         scrub.use_hi   <= ld_err_hi_r & ~ld_err_lo_r;
         scrub.addr_lo  <= lsu_addr_r;
         scrub.addr_hi  <= end_addr_r;
         scrub.fdata_lo <= {sec_ecc_lo_r, sec_data_lo_r};
         scrub.fdata_hi <= {sec_ecc_hi_r, sec_data_hi_r};
      end
   end

endmodule

`default_nettype wire

// File: source/dccm_ctl_top.sv
`timescale 1ns/10ps
`default_nettype none

module dccm_ctl_top
   import dccm_ctl_pkg::*;
(
   input  wire                 clk,
   input  wire                 reset,
   input  wire lsu_pkt_t       lsu_pkt_d,
   input  wire dccm_addr_t     lsu_addr_d,
   input  wire dccm_addr_t     end_addr_d,
   input  wire                 addr_in_dccm_d,
   input  wire                 lsu_commit_r,
   input  wire stbuf_req_t     stbuf,
   input  wire                 dma_dccm_wen,
   input  wire dccm_fdata_t    dma_wdata_lo,
   input  wire dccm_fdata_t    dma_wdata_hi,
   input  wire dma_tag_t       dma_mem_tag_m,
   input  wire dccm_data_t     stbuf_fwddata_lo_m,
   input  wire dccm_data_t     stbuf_fwddata_hi_m,
   input  wire dccm_byteen_t   stbuf_fwdbyteen_lo_m,
   input  wire dccm_byteen_t   stbuf_fwdbyteen_hi_m,
   input  wire dccm_fdata_t    dccm_rd_data_lo,       // memory output in m
   input  wire dccm_fdata_t    dccm_rd_data_hi,
   input  wire                 single_ecc_error_lo_r,
   input  wire                 single_ecc_error_hi_r,
   input  wire                 double_ecc_error_r,
   input  wire dccm_data_t     sec_data_lo_r,
   input  wire dccm_data_t     sec_data_hi_r,
   input  wire dccm_ecc_t      sec_ecc_lo_r,
   input  wire dccm_ecc_t      sec_ecc_hi_r,
   output dccm_wr_t            dccm_wr,
   output logic                dccm_rden,
   output dccm_addr_t          dccm_rd_addr_lo,
   output dccm_addr_t          dccm_rd_addr_hi,
   output logic                stbuf_commit,
   output dccm_data_t          lsu_ld_data_r,
   output dccm_data_t          lsu_ld_data_corr_r,
   output logic                ld_single_ecc_error_r,
   output logic                dccm_dma_rvalid,
   output logic                dccm_dma_ecc_error,
   output dma_tag_t            dccm_dma_rtag,
   output dccm_data_t [1:0]    dccm_dma_rdata
);

   lsu_pkt_t   lsu_pkt_r;
   dccm_addr_t lsu_addr_r;
   dccm_addr_t end_addr_r;
   scrub_req_t scrub;    // corrected word going back one cycle after r

   dccm_port_arb i_dccm_port_arb (.*);

   dccm_ld_pipe i_dccm_ld_pipe (.*);

   dccm_ecc_scrub i_dccm_ecc_scrub (.*);

endmodule

`default_nettype wire

// File: dv/dccm_ctl_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module dccm_ctl_clkgen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;    // 100 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: dv/dccm_ctl_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "dccm_ctl_config.svh"

module dccm_ctl_sva
   import dccm_ctl_pkg::*;
(
   input wire               clk,
   input wire               reset,
   input wire lsu_pkt_t     lsu_pkt_d,
   input wire dccm_addr_t   lsu_addr_d,
   input wire dccm_addr_t   end_addr_d,
   input wire               addr_in_dccm_d,
   input wire stbuf_req_t   stbuf,
   input wire               dma_dccm_wen,
   input wire dccm_fdata_t  dma_wdata_lo,
   input wire dccm_fdata_t  dma_wdata_hi,
   input wire dma_tag_t     dma_mem_tag_m,
   input wire dccm_byteen_t stbuf_fwdbyteen_lo_m,
   input wire dccm_byteen_t stbuf_fwdbyteen_hi_m,
   input wire dccm_addr_t   lsu_addr_r,
   input wire dccm_addr_t   end_addr_r,
   input wire               lsu_commit_r,
   input wire               single_ecc_error_lo_r,
   input wire               single_ecc_error_hi_r,
   input wire               double_ecc_error_r,
   input wire dccm_data_t   sec_data_lo_r,
   input wire dccm_data_t   sec_data_hi_r,
   input wire dccm_ecc_t    sec_ecc_lo_r,
   input wire dccm_ecc_t    sec_ecc_hi_r,
   input wire scrub_req_t   scrub,
   input wire dccm_wr_t     dccm_wr,
   input wire               dccm_rden,
   input wire dccm_addr_t   dccm_rd_addr_lo,
   input wire dccm_addr_t   dccm_rd_addr_hi,
   input wire               stbuf_commit,
   input wire               ld_single_ecc_error_r,
   input wire               dccm_dma_rvalid,
   input wire               dccm_dma_ecc_error,
   input wire dma_tag_t     dccm_dma_rtag,
   input wire dccm_data_t [1:0] dccm_dma_rdata
);

   int  fail_count = 0;
   logic sb_bank;
   logic other_bank;
   logic rd_d;
   logic ld_m;
   logic ld_r;
   logic dma_ld_m;
   logic dma_ld_r;
   logic ld_err_r;
   logic no_fwd_m;

   // own copy of the d to r pipe for the load flags
   always_ff @(posedge clk) begin
      ld_m     <= lsu_pkt_d.valid & lsu_pkt_d.load;
      ld_r     <= ld_m;
      dma_ld_m <= lsu_pkt_d.valid & lsu_pkt_d.load & lsu_pkt_d.dma;
      dma_ld_r <= dma_ld_m;
   end

   // loads and partial stores read, aligned full stores do not
   assign rd_d       = lsu_pkt_d.valid & addr_in_dccm_d &
                       (lsu_pkt_d.load | (lsu_pkt_d.store &
                        ~((lsu_pkt_d.word | lsu_pkt_d.dword) & (lsu_addr_d[1:0] == 2'b00))));
   assign sb_bank    = stbuf.addr[`DCCM_BANK_LSB];
   assign other_bank = (sb_bank != lsu_addr_d[`DCCM_BANK_LSB]) &
                       (sb_bank != end_addr_d[`DCCM_BANK_LSB]);
   assign ld_err_r   = ld_r & (single_ecc_error_lo_r | single_ecc_error_hi_r);
   assign no_fwd_m   = (stbuf_fwdbyteen_lo_m == '0) & (stbuf_fwdbyteen_hi_m == '0);

   load_reads_both_addr: assert property (@(posedge clk) disable iff (reset)
      lsu_pkt_d.valid & addr_in_dccm_d & lsu_pkt_d.load |->
      dccm_rden && dccm_rd_addr_lo == lsu_addr_d && dccm_rd_addr_hi == end_addr_d)
      else begin
         fail_count++;
         $error("load in D without matching read");
      end

   aligned_word_store_no_read: assert property (@(posedge clk) disable iff (reset)
      lsu_pkt_d.valid & lsu_pkt_d.store & lsu_pkt_d.word & (lsu_addr_d[1:0] == 2'b00) |->
      !dccm_rden)
      else begin
         fail_count++;
         $error("aligned word store raised dccm_rden");
      end

   commit_grant_rule: assert property (@(posedge clk) disable iff (reset)
      stbuf_commit == (stbuf.reqvld & ~dma_dccm_wen & ~scrub.valid & (~rd_d | other_bank)))
      else begin
         fail_count++;
         $error("stbuf_commit against grant rule");
      end

   commit_write_data: assert property (@(posedge clk) disable iff (reset)
      stbuf_commit |-> dccm_wr.wren && dccm_wr.addr_lo == stbuf.addr &&
      dccm_wr.addr_hi == stbuf.addr && dccm_wr.data_lo == {stbuf.ecc, stbuf.data} &&
      dccm_wr.data_hi == {stbuf.ecc, stbuf.data})
      else begin
         fail_count++;
         $error("store buffer write data wrong");
      end

   dma_rvalid_in_r: assert property (@(posedge clk) disable iff (reset)
      dccm_dma_rvalid == dma_ld_r)
      else begin
         fail_count++;
         $error("dccm_dma_rvalid not raised exactly for a dma load in R");
      end

   dma_read_return: assert property (@(posedge clk) disable iff (reset)
      dccm_dma_rvalid |-> dccm_dma_rtag == $past(dma_mem_tag_m) &&
      dccm_dma_ecc_error == double_ecc_error_r)
      else begin
         fail_count++;
         $error("dma tag or ecc error wrong");
      end

   dma_read_data: assert property (@(posedge clk) disable iff (reset)
      dccm_dma_rvalid && $past(no_fwd_m) && $past(addr_in_dccm_d, 2) |->
      ((lsu_addr_r[`DCCM_BANK_LSB] != end_addr_r[`DCCM_BANK_LSB]) ?
       dccm_dma_rdata == {sec_data_hi_r, sec_data_lo_r} :
       dccm_dma_rdata == {sec_data_lo_r, sec_data_lo_r}))
      else begin
         fail_count++;
         $error("dma read data wrong");
      end

   single_error_flag: assert property (@(posedge clk) disable iff (reset)
      ld_single_ecc_error_r == (ld_err_r & ~double_ecc_error_r))
      else begin
         fail_count++;
         $error("ld_single_ecc_error_r does not match the load error flags");
      end

   scrub_write_next: assert property (@(posedge clk) disable iff (reset)
      ld_err_r & ~double_ecc_error_r & (lsu_commit_r | dma_ld_r) |=>
      dccm_wr.wren && !stbuf_commit &&
      dccm_wr.addr_lo == $past(single_ecc_error_lo_r ? lsu_addr_r : end_addr_r) &&
      dccm_wr.addr_hi == $past(single_ecc_error_lo_r ? end_addr_r : lsu_addr_r) &&
      dccm_wr.data_lo == $past(single_ecc_error_lo_r ? {sec_ecc_lo_r, sec_data_lo_r} :
                                                       {sec_ecc_hi_r, sec_data_hi_r}) &&
      dccm_wr.data_hi == $past(single_ecc_error_lo_r ? {sec_ecc_hi_r, sec_data_hi_r} :
                                                       {sec_ecc_lo_r, sec_data_lo_r}))
      else begin
         fail_count++;
         $error("scrub write missing or wrong");
      end

   no_scrub_write: assert property (@(posedge clk) disable iff (reset)
      ld_err_r & (double_ecc_error_r | (~lsu_commit_r & ~dma_ld_r)) |=> !scrub.valid)
      else begin
         fail_count++;
         $error("unexpected scrub write");
      end

   dma_write_wins: assert property (@(posedge clk) disable iff (reset)
      dma_dccm_wen & ~scrub.valid |-> dccm_wr.wren && !stbuf_commit &&
      dccm_wr.addr_lo == lsu_addr_d && dccm_wr.addr_hi == end_addr_d &&
      dccm_wr.data_lo == dma_wdata_lo && dccm_wr.data_hi == dma_wdata_hi)
      else begin
         fail_count++;
         $error("dma write not on the port");
      end

endmodule

`default_nettype wire

// File: dv/dccm_ctl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dccm_ctl_tb
   import dccm_ctl_pkg::*;
();

   logic clk;
   logic reset;
   lsu_pkt_t lsu_pkt_d;
   dccm_addr_t lsu_addr_d, end_addr_d;
   logic addr_in_dccm_d, lsu_commit_r, dma_dccm_wen;
   stbuf_req_t stbuf;
   dccm_fdata_t dma_wdata_lo, dma_wdata_hi, dccm_rd_data_lo, dccm_rd_data_hi;
   dma_tag_t dma_mem_tag_m;
   dccm_data_t stbuf_fwddata_lo_m, stbuf_fwddata_hi_m;
   dccm_byteen_t stbuf_fwdbyteen_lo_m, stbuf_fwdbyteen_hi_m;
   logic single_ecc_error_lo_r, single_ecc_error_hi_r, double_ecc_error_r;
   dccm_data_t sec_data_lo_r, sec_data_hi_r;
   dccm_ecc_t sec_ecc_lo_r, sec_ecc_hi_r;
   dccm_wr_t dccm_wr;
   logic dccm_rden, stbuf_commit, ld_single_ecc_error_r;
   dccm_addr_t dccm_rd_addr_lo, dccm_rd_addr_hi;
   dccm_data_t lsu_ld_data_r, lsu_ld_data_corr_r;
   logic dccm_dma_rvalid, dccm_dma_ecc_error;
   dma_tag_t dccm_dma_rtag;
   dccm_data_t [1:0] dccm_dma_rdata;

   dccm_fdata_t mem [0:31];                  // word model, both banks
   dccm_addr_t rd_addr_lo_m = '0, rd_addr_hi_m = '0;
   lsu_pkt_t pkt_m;
   dccm_addr_t addr_m;
   logic in_dccm_m;
   logic chk_r;
   dccm_data_t exp_r;
   dccm_data_t exp_corr_r;
   dccm_data_t fwd_lo_r;
   dccm_data_t fwd_hi_r;
   dccm_byteen_t en_lo_r;
   dccm_byteen_t en_hi_r;
   logic in_dccm_r;
   logic [1:0] offset_r;
   int mismatches = 0;
   int total_errors;
   logic timed_out = 1'b0;
   int unsigned seed_val;

   dccm_ctl_clkgen i_clkgen (.clk(clk), .reset(reset));

   dccm_ctl_top i_dccm_ctl_top (.*);

   bind dccm_ctl_top dccm_ctl_sva i_sva (.*);

   initial begin
      for (int i = 0; i < 32; i++) begin
         mem[i] = dccm_fdata_t'({i[6:0], (i * 32'h0101_0101) ^ 32'h5a3c_96e1});
      end
   end

   always @(posedge clk) begin
      rd_addr_lo_m <= dccm_rd_addr_lo;
      rd_addr_hi_m <= dccm_rd_addr_hi;
      pkt_m        <= lsu_pkt_d;
      addr_m       <= lsu_addr_d;
      in_dccm_m    <= addr_in_dccm_d;
      if (dccm_wr.wren) begin
         mem[dccm_wr.addr_hi[6:2]] <= dccm_wr.data_hi;
         mem[dccm_wr.addr_lo[6:2]] <= dccm_wr.data_lo;   // lo wins on same word
      end
   end

   assign dccm_rd_data_lo = mem[rd_addr_lo_m[6:2]];   // memory answers in m
   assign dccm_rd_data_hi = mem[rd_addr_hi_m[6:2]];

   function automatic dccm_data_t merge_load(input dccm_data_t mem_lo, input dccm_data_t mem_hi,
                                             input dccm_data_t fwd_lo, input dccm_data_t fwd_hi,
                                             input dccm_byteen_t en_lo,
                                             input dccm_byteen_t en_hi,
                                             input logic in_dccm, input logic [1:0] offset);
      logic [63:0] mem_pair;
      logic [63:0] fwd_pair;
      logic [63:0] pair;
      logic [7:0]  en;
      mem_pair = {mem_hi, mem_lo};
      fwd_pair = {fwd_hi, fwd_lo};
      en = {en_hi, en_lo};
      for (int i = 0; i < 8; i++) begin
         pair[8*i +: 8] = en[i] ? fwd_pair[8*i +: 8] : (in_dccm ? mem_pair[8*i +: 8] : 8'h00);
      end
      pair = pair >> (8 * offset);
      return pair[31:0];
   endfunction

   // compare the load in r, then predict the one now in m
   always @(negedge clk) begin
      if (reset) begin
         chk_r = 1'b0;
      end else begin
         if (chk_r) begin
            exp_corr_r = merge_load(sec_data_lo_r, sec_data_hi_r, fwd_lo_r, fwd_hi_r,
                                    en_lo_r, en_hi_r, in_dccm_r, offset_r);
            if (lsu_ld_data_r !== exp_r) begin
               mismatches++;
               $display("Mismatch at %0t: lsu_ld_data_r got %h expected %h",
                        $time, lsu_ld_data_r, exp_r);
            end
            if (lsu_ld_data_corr_r !== exp_corr_r) begin
               mismatches++;
               $display("Mismatch at %0t: lsu_ld_data_corr_r got %h expected %h",
                        $time, lsu_ld_data_corr_r, exp_corr_r);
            end
         end
         chk_r = pkt_m.valid & pkt_m.load;
         exp_r = merge_load(dccm_rd_data_lo[31:0], dccm_rd_data_hi[31:0],
                            stbuf_fwddata_lo_m, stbuf_fwddata_hi_m,
                            stbuf_fwdbyteen_lo_m, stbuf_fwdbyteen_hi_m,
                            in_dccm_m, addr_m[1:0]);
         fwd_lo_r  = stbuf_fwddata_lo_m;     // corrected word merges these in r
         fwd_hi_r  = stbuf_fwddata_hi_m;
         en_lo_r   = stbuf_fwdbyteen_lo_m;
         en_hi_r   = stbuf_fwdbyteen_hi_m;
         in_dccm_r = in_dccm_m;
         offset_r  = addr_m[1:0];
      end
   end

   task automatic drive_random_cycle();
      lsu_pkt_t   pkt;
      dccm_addr_t a;
      int         sz;
      pkt = '0;
      pkt.valid = ($urandom % 4) != 0;
      pkt.load = ($urandom % 4) != 3;
      pkt.store = ~pkt.load;
      sz = $urandom % 3;
      a = dccm_addr_t'($urandom & 32'h7f);
      if (pkt.store && ($urandom % 2)) begin   // aligned word store
         sz = 2;
         a[1:0] = 2'b00;
      end
      pkt.by = (sz == 0);
      pkt.half = (sz == 1);
      pkt.word = (sz == 2);
      pkt.dma = pkt.load & (($urandom % 4) == 0);
      lsu_pkt_d <= pkt;
      lsu_addr_d <= a;
      end_addr_d <= a + dccm_addr_t'((1 << sz) - 1);
      addr_in_dccm_d <= pkt.dma | (($urandom % 8) != 0);
      dma_dccm_wen <= ($urandom % 8) == 0;
      dma_wdata_lo <= dccm_fdata_t'({$urandom, $urandom});
      dma_wdata_hi <= dccm_fdata_t'({$urandom, $urandom});
      dma_mem_tag_m <= dma_tag_t'($urandom);
      stbuf_fwddata_lo_m <= $urandom;
      stbuf_fwddata_hi_m <= $urandom;
      stbuf_fwdbyteen_lo_m <= lsu_pkt_d.dma ? '0 : dccm_byteen_t'($urandom & $urandom);
      stbuf_fwdbyteen_hi_m <= lsu_pkt_d.dma ? '0 : dccm_byteen_t'($urandom & $urandom);
      lsu_commit_r <= $urandom % 2;
      single_ecc_error_lo_r <= ($urandom % 4) == 0;
      single_ecc_error_hi_r <= ($urandom % 4) == 0;
      double_ecc_error_r <= ($urandom % 8) == 0;
      sec_data_lo_r <= $urandom;
      sec_data_hi_r <= $urandom;
      sec_ecc_lo_r <= dccm_ecc_t'($urandom);
      sec_ecc_hi_r <= dccm_ecc_t'($urandom);
      if (!stbuf.reqvld || stbuf_commit) begin     // held until committed
         stbuf.reqvld <= ($urandom % 3) == 0;
         stbuf.addr <= dccm_addr_t'($urandom & 32'h7f);
         stbuf.data <= $urandom;
         stbuf.ecc <= dccm_ecc_t'($urandom);
      end
   endtask

   initial begin
      seed_val = $urandom(32'hee2f_f5c5);
      lsu_pkt_d <= '0;
      lsu_addr_d <= '0;
      end_addr_d <= '0;
      addr_in_dccm_d <= 1'b0;
      lsu_commit_r <= 1'b0;
      stbuf <= '0;
      dma_dccm_wen <= 1'b0;
      dma_wdata_lo <= '0;
      dma_wdata_hi <= '0;
      dma_mem_tag_m <= '0;
      stbuf_fwddata_lo_m <= '0;
      stbuf_fwddata_hi_m <= '0;
      stbuf_fwdbyteen_lo_m <= '0;
      stbuf_fwdbyteen_hi_m <= '0;
      single_ecc_error_lo_r <= 1'b0;
      single_ecc_error_hi_r <= 1'b0;
      double_ecc_error_r <= 1'b0;
      sec_data_lo_r <= '0;
      sec_data_hi_r <= '0;
      sec_ecc_lo_r <= '0;
      sec_ecc_hi_r <= '0;

      for (int n = 0; n < 10 && reset !== 1'b0; n++) @(posedge clk);
      if (reset !== 1'b0) begin
         timed_out = 1'b1;
         $display("Timeout: reset was never released");
      end else begin
         repeat (400) begin
            @(posedge clk);
            drive_random_cycle();
         end
         // let the store buffer drain with the pipe idle
         for (int n = 0; n < 50 && stbuf.reqvld; n++) begin
            @(posedge clk);
            lsu_pkt_d <= '0;
            dma_dccm_wen <= 1'b0;
            single_ecc_error_lo_r <= 1'b0;
            single_ecc_error_hi_r <= 1'b0;
            if (stbuf_commit) stbuf.reqvld <= 1'b0;
         end
         repeat (3) @(posedge clk);
         if (stbuf.reqvld) begin
            timed_out = 1'b1;
            $display("Timeout: store buffer request was never committed");
         end
      end

      total_errors = mismatches + i_dccm_ctl_top.i_sva.fail_count;
      $display("errors: %0d mismatches, %0d assertion failures, timeout %0d",
               mismatches, i_dccm_ctl_top.i_sva.fail_count, timed_out);
      if (total_errors == 0 && !timed_out) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/dccm_ctl_pkg.sv
source/dccm_port_arb.sv
source/dccm_ld_pipe.sv
source/dccm_ecc_scrub.sv
source/dccm_ctl_top.sv
dv/dccm_ctl_clkgen.sv
dv/dccm_ctl_sva.sv
dv/dccm_ctl_tb.sv

// File: Bender.yml
package:
  name: dccm_ctl

sources:
  - include_dirs:
      - source
    files:
      - source/dccm_ctl_pkg.sv
      - source/dccm_port_arb.sv
      - source/dccm_ld_pipe.sv
      - source/dccm_ecc_scrub.sv
      - source/dccm_ctl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/dccm_ctl_clkgen.sv
      - dv/dccm_ctl_sva.sv
      - dv/dccm_ctl_tb.sv
